// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen      = 32; // Data word width
    localparam int reg_idx_w = 5;

    // Major opcodes of the kept instructions
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;

    localparam logic [2:0] f3_add_sub = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_word    = 3'b010; // LW and SW width

    // Instruction bit that turns ADD into SUB
    localparam int f7_alt_bit = 30;

    // One instruction word, five ways of reading it
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [reg_idx_w-1:0] rs2;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } r_fmt;
        struct packed {
            logic [11:0]          imm_11_0;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } i_fmt;
        struct packed {
            logic [6:0]           imm_11_5;
            logic [reg_idx_w-1:0] rs2;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           imm_4_0;
            logic [6:0]           opcode;
        } s_fmt;
        struct packed {
            logic                 imm_12;
            logic [5:0]           imm_10_5;
            logic [reg_idx_w-1:0] rs2;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [3:0]           imm_4_1;
            logic                 imm_11;
            logic [6:0]           opcode;
        } b_fmt;
        struct packed {
            logic [19:0]          imm_31_12;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } u_fmt;
    } rv_instr_u;

endpackage

`default_nettype wire

// File: hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // ALU operation select
    localparam int alu_op_w = 4;

    // Codes 5 to 8 unused
    localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
    localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
    localparam logic [alu_op_w-1:0] alu_and  = 4'd2;
    localparam logic [alu_op_w-1:0] alu_or   = 4'd3;
    localparam logic [alu_op_w-1:0] alu_xor  = 4'd4;
    localparam logic [alu_op_w-1:0] alu_sltu = 4'd9;  // Unsigned compare
    localparam logic [alu_op_w-1:0] alu_slt  = 4'd10; // Signed compare

    // Write-back source select
    localparam int wb_src_w = 2;

    localparam logic [wb_src_w-1:0] wb_alu  = 2'd0; // ALU result
    localparam logic [wb_src_w-1:0] wb_load = 2'd1; // Data memory read
    localparam logic [wb_src_w-1:0] wb_imm  = 2'd2; // LUI immediate

endpackage

`default_nettype wire

// File: hdl/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
#(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
)
(
    input  wire                         clk,
    input  wire                         RESET_N,
    input  wire                         branch_taken,
    input  wire  [rv_isa_pkg::xlen-1:0] branch_target,
    output logic [rv_isa_pkg::xlen-1:0] pc,
    output logic [rv_isa_pkg::xlen-1:0] pc_next_seq
);

    import rv_isa_pkg::*;

    // Fall-through address, one word ahead
    assign pc_next_seq = pc + xlen'(4);

    // One PC update per instruction
    always_ff @(posedge clk or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            pc <= reset_pc;
        end
        else if (branch_taken)
        begin
            pc <= branch_target;
        end
        else
        begin
            pc <= pc_next_seq;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  wire  rv_isa_pkg::rv_instr_u             instr,
    output logic [rv_isa_pkg::reg_idx_w-1:0]        rs1_idx,
    output logic [rv_isa_pkg::reg_idx_w-1:0]        rs2_idx,
    output logic [rv_isa_pkg::reg_idx_w-1:0]        rd_idx,
    output logic [rv_isa_pkg::xlen-1:0]             imm,
    output logic [2:0]                              funct3,
    output logic                                    reg_write,
    output logic                                    mem_read,
    output logic                                    mem_write,
    output logic                                    branch,
    output logic                                    alu_src,
    output logic [rv_core_pkg::alu_op_w-1:0]        alu_op,
    output logic [rv_core_pkg::wb_src_w-1:0]        wb_src
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [6:0]          opcode;
    logic                is_sub;
    logic [alu_op_w-1:0] arith_op;  // ALU op for register and immediate forms
    logic                arith_ok;

    assign opcode  = instr.r_fmt.opcode;
    assign funct3  = instr.r_fmt.funct3;
    assign rs1_idx = instr.r_fmt.rs1;
    assign rs2_idx = instr.r_fmt.rs2;
    assign rd_idx  = instr.r_fmt.rd;

    // Bit 30 only means SUB in the register form; ADDI keeps it as immediate
    assign is_sub = (opcode == op_reg) && instr[f7_alt_bit];

    always_comb
    begin
        arith_ok = 1'b1;
        case (funct3)
            f3_add_sub: arith_op = is_sub ? alu_sub : alu_add;
            f3_slt:     arith_op = alu_slt;
            f3_sltu:    arith_op = alu_sltu;
            f3_xor:     arith_op = alu_xor;
            f3_or:      arith_op = alu_or;
            f3_and:     arith_op = alu_and;
            default:
            begin
                arith_op = alu_add;
                arith_ok = 1'b0; // Shifts are not supported
            end
        endcase
    end

    always_comb
    begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        alu_src   = 1'b0;
        alu_op    = alu_add;
        wb_src    = wb_alu;
        imm       = '0;
        case (opcode)
            op_reg:
            begin
                reg_write = arith_ok;
                alu_op    = arith_op;
            end
            op_imm:
            begin
                reg_write = arith_ok;
                alu_src   = 1'b1;
                alu_op    = arith_op;
                imm       = {{(xlen-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            end
            op_load:
            begin
                reg_write = (funct3 == f3_word); // LW only
                mem_read  = (funct3 == f3_word);
                alu_src   = 1'b1;
                wb_src    = wb_load;
                imm       = {{(xlen-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            end
            op_store:
            begin
                mem_write = (funct3 == f3_word);
                alu_src   = 1'b1;
                imm       = {{(xlen-12){instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                             instr.s_fmt.imm_4_0};
            end
            op_branch:
            begin
                branch = (funct3 == f3_beq) || (funct3 == f3_bne);
                alu_op = (funct3 == f3_beq) ? alu_sub : alu_xor; // Zero means equal
                imm    = {{(xlen-12){instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                          instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            end
            op_lui:
            begin
                reg_write = 1'b1;
                wb_src    = wb_imm;
                imm       = {instr.u_fmt.imm_31_12, 12'b0};
            end
            default:
            begin
                reg_write = 1'b0; // Unknown opcode does nothing
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file
(
    input  wire                              clk,
    input  wire                              RESET_N,
    input  wire  [rv_isa_pkg::reg_idx_w-1:0] rs1_idx,
    input  wire  [rv_isa_pkg::reg_idx_w-1:0] rs2_idx,
    input  wire  [rv_isa_pkg::reg_idx_w-1:0] rd_idx,
    input  wire                              rd_we,
    input  wire  [rv_isa_pkg::xlen-1:0]      rd_data,
    output logic [rv_isa_pkg::xlen-1:0]      rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]      rs2_data
);

    import rv_isa_pkg::*;

    localparam int num_regs = 2 ** reg_idx_w;

    logic [xlen-1:0] regs [num_regs];

    // x0 is never targeted by a write, so it reads back zero
    always_ff @(posedge clk or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rd_we)
        begin
            regs[rd_idx] <= rd_data;
        end
    end

    // Read ports see the old value until the edge
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute
(
    input  wire  [rv_isa_pkg::xlen-1:0]      pc,
    input  wire  [rv_isa_pkg::xlen-1:0]      rs1_data,
    input  wire  [rv_isa_pkg::xlen-1:0]      rs2_data,
    input  wire  [rv_isa_pkg::xlen-1:0]      imm,
    input  wire                              alu_src,
    input  wire  [rv_core_pkg::alu_op_w-1:0] alu_op,
    input  wire                              branch,
    input  wire  [2:0]                       funct3,
    output logic [rv_isa_pkg::xlen-1:0]      alu_result,
    output logic                             branch_taken,
    output logic [rv_isa_pkg::xlen-1:0]      branch_target
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [xlen-1:0] op_b;
    logic            alu_zero;

    // Immediate forms and memory ops take imm
    assign op_b = alu_src ? imm : rs2_data;

    always_comb
    begin
        case (alu_op)
            alu_add:  alu_result = rs1_data + op_b;
            alu_sub:  alu_result = rs1_data - op_b;
            alu_and:  alu_result = rs1_data & op_b;
            alu_or:   alu_result = rs1_data | op_b;
            alu_xor:  alu_result = rs1_data ^ op_b;
            alu_sltu:
            begin
                alu_result = {{(xlen-1){1'b0}}, (rs1_data < op_b)};
            end
            alu_slt:
            begin
                alu_result = {{(xlen-1){1'b0}}, ($signed(rs1_data) < $signed(op_b))};
            end
            default:  alu_result = '0;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    // BEQ on zero, BNE on non-zero
    always_comb
    begin
        branch_taken = 1'b0;
        if (branch)
        begin
            case (funct3)
                f3_beq:  branch_taken = alu_zero;
                f3_bne:  branch_taken = !alu_zero;
                default: branch_taken = 1'b0;
            endcase
        end
    end

    assign branch_target = pc + imm; // B immediate already has bit 0 clear

endmodule

`default_nettype wire

// File: hdl/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result
(
    input  wire  [rv_isa_pkg::xlen-1:0]      alu_result,
    input  wire  [rv_isa_pkg::xlen-1:0]      rs2_data,
    input  wire  [rv_isa_pkg::xlen-1:0]      imm,
    input  wire  [rv_isa_pkg::xlen-1:0]      dmem_rdata,
    input  wire                              mem_read,
    input  wire                              mem_write,
    input  wire                              reg_write,
    input  wire  [rv_core_pkg::wb_src_w-1:0] wb_src,
    input  wire  [rv_isa_pkg::reg_idx_w-1:0] rd_idx,
    output logic [rv_isa_pkg::xlen-1:0]      dmem_addr,
    output logic [rv_isa_pkg::xlen-1:0]      dmem_wdata,
    output logic                             dmem_we,
    output logic                             dmem_re,
    output logic                             rd_we,
    output logic [rv_isa_pkg::xlen-1:0]      rd_data
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    // Word accesses only
    assign dmem_addr  = {alu_result[xlen-1:2], 2'b00};
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_write;
    assign dmem_re    = mem_read;

    // Writes to x0 are dropped here
    assign rd_we = reg_write && (rd_idx != '0);

    always_comb
    begin
        case (wb_src)
            wb_load: rd_data = dmem_rdata;
            wb_imm:  rd_data = imm;        // LUI
            default: rd_data = alu_result; // wb_alu
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
#(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
)
(
    input  wire                                clk,
    input  wire                                RESET_N,
    output logic [rv_isa_pkg::xlen-1:0]        imem_addr,
    input  wire  [rv_isa_pkg::xlen-1:0]        imem_data,
    output logic [rv_isa_pkg::xlen-1:0]        dmem_addr,
    output logic [rv_isa_pkg::xlen-1:0]        dmem_wdata,
    output logic                               dmem_we,
    output logic                               dmem_re,
    input  wire  [rv_isa_pkg::xlen-1:0]        dmem_rdata,
    output logic                               wb_en,
    output logic [rv_isa_pkg::reg_idx_w-1:0]   wb_rd,
    output logic [rv_isa_pkg::xlen-1:0]        wb_data
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [xlen-1:0]      pc;
    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;
    logic [reg_idx_w-1:0] rd_idx;
    logic [xlen-1:0]      imm;
    logic [2:0]           funct3;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 branch;
    logic                 alu_src;
    logic [alu_op_w-1:0]  alu_op;
    logic [wb_src_w-1:0]  wb_src;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic [xlen-1:0]      alu_result;
    logic                 branch_taken;
    logic [xlen-1:0]      branch_target;
    logic                 rd_we;
    logic [xlen-1:0]      rd_data;

    assign imem_addr = pc;
    assign wb_en     = rd_we;   // Register write seen by the testbench
    assign wb_rd     = rd_idx;
    assign wb_data   = rd_data;

    rv_fetch #(.reset_pc(reset_pc)) i_fetch (
        .clk           (clk),
        .RESET_N       (RESET_N),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .pc_next_seq   ()
    );

    rv_decode i_decode (
        .instr     (imem_data),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rd_idx    (rd_idx),
        .imm       (imm),
        .funct3    (funct3),
        .reg_write (reg_write),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .branch    (branch),
        .alu_src   (alu_src),
        .alu_op    (alu_op),
        .wb_src    (wb_src)
    );

    rv_reg_file i_reg_file (
        .clk      (clk),
        .RESET_N  (RESET_N),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rd_idx   (rd_idx),
        .rd_we    (rd_we),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute i_execute (
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .imm           (imm),
        .alu_src       (alu_src),
        .alu_op        (alu_op),
        .branch        (branch),
        .funct3        (funct3),
        .alu_result    (alu_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    rv_result i_result (
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .dmem_rdata (dmem_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .reg_write  (reg_write),
        .wb_src     (wb_src),
        .rd_idx     (rd_idx),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .rd_we      (rd_we),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

// File: verif/rv_core_model.svh
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// Galois LFSR, one step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
        bits       = {bits[30:0], lfsr_state[0]};
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return bits;
endfunction

// ISA arithmetic for the kept funct3 values
function automatic logic [xlen-1:0] arith_ref(input logic [2:0] f3, input logic sub,
                                              input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b010:  return ($signed(a) < $signed(b)) ? 1 : 0;
        3'b011:  return (a < b) ? 1 : 0;
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return '0;
    endcase
endfunction

// Expected effect of one instruction on the model state
function automatic void predict_instr(input logic [xlen-1:0] instr);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    a     = ref_regs[instr[19:15]];
    b     = ref_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    exp_we    = 1'b0;
    exp_rd    = instr[11:7];
    exp_wdata = '0;
    exp_st    = 1'b0;
    exp_ld    = 1'b0;
    exp_addr  = '0;
    exp_sdata = '0;
    exp_pc    = ref_pc + 4;
    case (instr[6:0])
        op_reg:
        begin
            exp_we    = 1'b1;
            exp_wdata = arith_ref(instr[14:12], instr[30], a, b);
        end
        op_imm:
        begin
            exp_we    = 1'b1;
            exp_wdata = arith_ref(instr[14:12], 1'b0, a, imm_i); // No SUBI
        end
        op_load:
        begin
            exp_we    = 1'b1;
            exp_ld    = 1'b1;
            exp_addr  = a + imm_i;
            exp_wdata = ref_mem[exp_addr[5:2]];
        end
        op_store:
        begin
            exp_st    = 1'b1;
            exp_addr  = a + imm_s;
            exp_sdata = b;
        end
        op_branch:
        begin
            if ((instr[14:12] == 3'b000) == (a == b))
                exp_pc = ref_pc + imm_b; // BEQ on equal, BNE on not equal
        end
        op_lui:
        begin
            exp_we    = 1'b1;
            exp_wdata = {instr[31:12], 12'h000};
        end
        default: ;
    endcase
    if (exp_rd == '0)
        exp_we = 1'b0;
endfunction

task automatic commit_model();
    if (exp_we)
        ref_regs[exp_rd] = exp_wdata;
    if (exp_st)
        ref_mem[exp_addr[5:2]] = exp_sdata;
    ref_pc = exp_pc;
endtask

task automatic clear_model();
    ref_regs = '{default: '0};
    ref_mem  = '{default: '0};
    dmem     = '{default: '0};
    ref_pc   = reset_pc;
endtask

task automatic check_word(input string name, input logic [xlen-1:0] act,
                          input logic [xlen-1:0] exp);
    if (act !== exp)
    begin
        $display("MISMATCH %s: got 0x%h, expected 0x%h (pc 0x%h)", name, act, exp, ref_pc);
        $display("Test failed");
        $fatal(1);
    end
endtask

task automatic check_idx(input string name, input logic [reg_idx_w-1:0] act,
                         input logic [reg_idx_w-1:0] exp);
    if (act !== exp)
    begin
        $display("MISMATCH %s: got 0x%h, expected 0x%h (pc 0x%h)", name, act, exp, ref_pc);
        $display("Test failed");
        $fatal(1);
    end
endtask

task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
        $display("MISMATCH %s: got 0x%h, expected 0x%h (pc 0x%h)", name, act, exp, ref_pc);
        $display("Test failed");
        $fatal(1);
    end
endtask

`endif

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    import rv_isa_pkg::*;

    localparam logic [xlen-1:0] reset_pc = '0;
    localparam int clk_period  = 100;
    localparam int rst_cycles  = 2;
    localparam int prog_len    = 256;
    localparam int tail_cycles = 20; // Cycles spent in the final self-loop
    localparam int wdog_cycles = prog_len + rst_cycles + tail_cycles + 8;
    localparam logic [31:0]     lfsr_seed = 32'h2d50_b636;
    localparam logic [xlen-1:0] last_pc   = (prog_len - 1) * 4;

    logic                 clk;
    logic                 RESET_N;
    logic [xlen-1:0]      imem_addr;
    logic [xlen-1:0]      imem_data;
    logic [xlen-1:0]      dmem_addr;
    logic [xlen-1:0]      dmem_wdata;
    logic                 dmem_we;
    logic                 dmem_re;
    logic [xlen-1:0]      dmem_rdata;
    logic                 wb_en;
    logic [reg_idx_w-1:0] wb_rd;
    logic [xlen-1:0]      wb_data;

    logic [xlen-1:0] imem [prog_len];
    logic [xlen-1:0] dmem [16];       // Written by the DUT's stores
    logic [xlen-1:0] ref_mem [16];
    logic [xlen-1:0] ref_regs [32];
    logic [xlen-1:0] ref_pc;
    logic [31:0]     lfsr_state;

    // Model prediction for the instruction in flight
    logic                 exp_we;
    logic [reg_idx_w-1:0] exp_rd;
    logic [xlen-1:0]      exp_wdata;
    logic                 exp_st;
    logic                 exp_ld;
    logic [xlen-1:0]      exp_addr;
    logic [xlen-1:0]      exp_sdata;
    logic [xlen-1:0]      exp_pc;

    `include "rv_core_model.svh"

    rv_core_top #(.reset_pc(reset_pc)) i_dut (
        .clk        (clk),
        .RESET_N    (RESET_N),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // Random mix of the kept kinds over x0 to x7
    task automatic build_program();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [3:0]  off;
        lfsr_state = lfsr_seed;
        for (int i = 0; i < prog_len - 1; i++)
        begin
            kind  = 3'(rand_bits(3));
            f3    = 3'(rand_bits(3) % 6);
            f3    = (f3 == 3'd0) ? 3'b000 : (f3 < 3'd3) ? f3 + 3'd1
                  : (f3 == 3'd3) ? 3'b100 : f3 + 3'd2;
            rd    = 5'(rand_bits(3));
            rs1   = 5'(rand_bits(3));
            rs2   = 5'(rand_bits(3));
            imm12 = 12'(rand_bits(12));
            off   = 4'(rand_bits(4));
            if (i < 8)
            begin
                kind = 3'd2; // Seeding ADDI, x0 included
                f3   = f3_add_sub;
            end
            if (kind == 3'd6 && i > prog_len - 4)
                kind = 3'd2; // Keep branch targets inside the program
            case (kind)
                3'd0, 3'd1: imem[i] = {(f3 == 3'b000 && rand_bits(1)) ? 7'b0100000 : 7'b0,
                                       rs2, rs1, f3, rd, op_reg};
                3'd2, 3'd3: imem[i] = {imm12, (i < 8) ? 5'd0 : rs1, f3,
                                       (i < 8) ? 5'(i) : rd, op_imm};
                3'd4:       imem[i] = {6'd0, off, 2'b00, 5'd0, f3_word, rd, op_load};
                3'd5:       imem[i] = {6'd0, off[3], rs2, 5'd0, f3_word, off[2:0], 2'b00, op_store};
                3'd6:       imem[i] = {7'd0, rs2, rs1, off[0] ? f3_bne : f3_beq,
                                       off[1] ? 4'b0110 : 4'b0100, 1'b0, op_branch}; // +12 or +8
                default:    imem[i] = {20'(rand_bits(20)), rd, op_lui};
            endcase
        end
        imem[prog_len-1] = {7'd0, 5'd0, 5'd0, f3_beq, 4'd0, 1'b0, op_branch}; // Loop in place
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(wdog_cycles * clk_period);
        $display("Timeout after %0d cycles without reaching the final loop", wdog_cycles);
        $display("Test failed");
        $fatal(1);
    end

    initial
    begin
        logic [xlen-1:0] nxt;
        logic [xlen-1:0] ld_addr;
        int              loop_count;
        loop_count = 0;
        RESET_N    <= 1'b0;
        build_program();
        clear_model();
        imem_data  <= imem[0];
        dmem_rdata <= '0;
        repeat (rst_cycles) @(posedge clk);
        RESET_N <= 1'b1;
        while (loop_count < tail_cycles)
        begin
            @(posedge clk);
            predict_instr(imem[ref_pc[9:2]]);
            check_word("imem_addr", imem_addr, ref_pc);
            check_flag("wb_en", wb_en, exp_we);
            if (exp_we)
            begin
                check_idx("wb_rd", wb_rd, exp_rd);
                check_word("wb_data", wb_data, exp_wdata);
            end
            check_flag("dmem_we", dmem_we, exp_st);
            check_flag("dmem_re", dmem_re, exp_ld);
            if (exp_st || exp_ld)
                check_word("dmem_addr", dmem_addr, exp_addr);
            if (exp_st)
                check_word("dmem_wdata", dmem_wdata, exp_sdata);
            if (dmem_we)
                dmem[dmem_addr[5:2]] = dmem_wdata;
            if (ref_pc == last_pc)
                loop_count++;
            commit_model();
            // Answer the next fetch and its load address
            nxt        = imem[ref_pc[9:2]];
            ld_addr    = ref_regs[nxt[19:15]] + {{20{nxt[31]}}, nxt[31:20]};
            imem_data  <= nxt;
            dmem_rdata <= dmem[ld_addr[5:2]];
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+verif
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_reg_file.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core_top.sv
verif/rv_core_tb.sv
